//--- rtl/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Machine word
`define DATA_WIDTH 32

// Instruction memory, in words
`define IMEM_DEPTH 64
`define IMEM_AW    6

// Data memory, in words
`define DMEM_DEPTH 64
`define DMEM_AW    6

`define REG_A0 10 // x10, the a0 result register

`endif

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL,
        ALU_PASS_B // second operand straight through
    } alu_op_e;

    // Field layouts, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo; // imm[4:0]
        opcode_e    opcode;
    } s_fmt_t;

    // Scrambled branch offset, bit 0 implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm; // imm[31:12]
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One instruction word, six readings
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
        logic [31:0] raw;
    } rv_instr_u;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
`default_nettype none
`include "rv_macros.svh"

module fetch_unit import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   take_branch_i,  // Branch taken or jump
    input  logic [`DATA_WIDTH-1:0] pc_target_i,
    input  logic                   imem_wr_en_i,   // Program load port
    input  logic [`IMEM_AW-1:0]    imem_wr_addr_i,
    input  logic [`DATA_WIDTH-1:0] imem_wr_data_i,
    output logic [`DATA_WIDTH-1:0] pc_o,
    output logic [`DATA_WIDTH-1:0] pc_plus4_o,
    output rv_instr_u              instr_o
);

    logic [`DATA_WIDTH-1:0] imem [`IMEM_DEPTH];
    logic [`DATA_WIDTH-1:0] pc_next;

    assign pc_plus4_o = pc_o + `DATA_WIDTH'(4);
    assign pc_next    = take_branch_i ? pc_target_i : pc_plus4_o; // No bubble on redirect

    // PC moves every edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= '0; // Restart at word 0
        end else begin
            pc_o <= pc_next;
        end
    end

    // Loader only writes while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset_i && imem_wr_en_i) begin
            imem[imem_wr_addr_i] <= imem_wr_data_i;
        end
    end

    // Asynchronous read by word address
    assign instr_o = imem[pc_o[`IMEM_AW+1:2]];

endmodule

`default_nettype wire

//--- rtl/control_unit.sv
`default_nettype none
`include "rv_macros.svh"

module control_unit import rv_pkg::*; (
    input  rv_instr_u              instr_i,
    output logic [4:0]             rs1_addr_o,
    output logic [4:0]             rs2_addr_o,
    output logic [4:0]             rd_addr_o,
    output logic [`DATA_WIDTH-1:0] imm_o,        // Sign-extended immediate
    output alu_op_e                alu_op_o,
    output logic                   src_a_pc_o,   // AUIPC
    output logic                   src_a_zero_o, // LUI
    output logic                   src_b_imm_o,
    output logic                   reg_wr_en_o,
    output logic                   mem_wr_en_o,
    output logic [1:0]             result_sel_o, // 0 ALU, 1 load, 2 link
    output logic                   branch_o,
    output logic                   jump_o,       // JAL and JALR
    output logic                   jalr_o
);

    opcode_e                opcode;
    logic [2:0]             funct3;
    logic                   funct7_5;
    alu_op_e                arith_op;
    logic [`DATA_WIDTH-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;

    // Fields at the same spot in every format
    assign opcode     = instr_i.r.opcode;
    assign funct3     = instr_i.r.funct3;
    assign funct7_5   = instr_i.r.funct7[5]; // SUB select
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;
    assign rd_addr_o  = instr_i.r.rd;

    // Immediates, one per format view
    assign i_imm = {{(`DATA_WIDTH-12){instr_i.i.imm[11]}}, instr_i.i.imm};
    assign s_imm = {{(`DATA_WIDTH-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign b_imm = {{(`DATA_WIDTH-12){instr_i.b.imm_12}}, instr_i.b.imm_11,
                    instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign u_imm = {instr_i.u.imm, 12'b0}; // Already shifted into place
    assign j_imm = {{(`DATA_WIDTH-20){instr_i.j.imm_20}}, instr_i.j.imm_19_12,
                    instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

    // Register and immediate arithmetic share funct3
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = ALU_SRL; // no SRA in this core
            3'b110:  arith_op = ALU_OR;
            3'b111:  arith_op = ALU_AND;
            default: arith_op = ALU_ADD; // SLTU not supported
        endcase
    end

    always_comb begin
        // Everything idle unless the opcode says otherwise
        imm_o        = '0;
        alu_op_o     = ALU_ADD;
        src_a_pc_o   = 1'b0;
        src_a_zero_o = 1'b0;
        src_b_imm_o  = 1'b0;
        reg_wr_en_o  = 1'b0;
        mem_wr_en_o  = 1'b0;
        result_sel_o = 2'd0;
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        jalr_o       = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op_o    = arith_op;
                reg_wr_en_o = 1'b1;
            end
            OPC_OP_IMM: begin
                imm_o       = i_imm;
                alu_op_o    = arith_op;
                src_b_imm_o = 1'b1;
                reg_wr_en_o = 1'b1;
            end
            OPC_LOAD: begin
                imm_o        = i_imm; // Address is rs1 + imm
                src_b_imm_o  = 1'b1;
                reg_wr_en_o  = 1'b1;
                result_sel_o = 2'd1;
            end
            OPC_STORE: begin
                imm_o       = s_imm;
                src_b_imm_o = 1'b1;
                mem_wr_en_o = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o    = b_imm; // Compare happens in execute
                branch_o = 1'b1;
            end
            OPC_JAL: begin
                imm_o        = j_imm;
                alu_op_o     = ALU_PASS_B; // ALU result unused, link is PC+4
                jump_o       = 1'b1;
                reg_wr_en_o  = 1'b1;
                result_sel_o = 2'd2;
            end
            OPC_JALR: begin
                imm_o        = i_imm;
                alu_op_o     = ALU_PASS_B;
                jump_o       = 1'b1;
                jalr_o       = 1'b1; // Target based on rs1
                reg_wr_en_o  = 1'b1;
                result_sel_o = 2'd2;
            end
            OPC_LUI: begin
                imm_o        = u_imm;
                src_a_zero_o = 1'b1; // 0 + imm
                src_b_imm_o  = 1'b1;
                reg_wr_en_o  = 1'b1;
            end
            OPC_AUIPC: begin
                imm_o       = u_imm;
                src_a_pc_o  = 1'b1; // PC + imm
                src_b_imm_o = 1'b1;
                reg_wr_en_o = 1'b1;
            end
            default: ; // Unknown opcode acts as NOP
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`default_nettype none
`include "rv_macros.svh"

module register_file import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [4:0]             rs1_addr_i,
    input  logic [4:0]             rs2_addr_i,
    input  logic [4:0]             rd_addr_i,
    input  logic [`DATA_WIDTH-1:0] rd_data_i,
    input  logic                   wr_en_i,
    output logic [`DATA_WIDTH-1:0] rs1_data_o,
    output logic [`DATA_WIDTH-1:0] rs2_data_o,
    output logic [`DATA_WIDTH-1:0] a0_o        // Result tap
);

    logic [`DATA_WIDTH-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en_i && rd_addr_i != 5'd0) begin // x0 never written
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // Reads see the value before this edge's write
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];
    assign a0_o       = regs[`REG_A0];

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
`default_nettype none
`include "rv_macros.svh"

module execute_unit import rv_pkg::*; (
    input  logic [`DATA_WIDTH-1:0] pc_i,
    input  logic [`DATA_WIDTH-1:0] rs1_data_i,
    input  logic [`DATA_WIDTH-1:0] rs2_data_i,
    input  logic [`DATA_WIDTH-1:0] imm_i,
    input  alu_op_e                alu_op_i,
    input  logic                   src_a_pc_i,
    input  logic                   src_a_zero_i,
    input  logic                   src_b_imm_i,
    input  logic                   branch_i,
    input  logic                   jump_i,
    input  logic                   jalr_i,
    input  logic [2:0]             funct3_i,      // Branch kind
    output logic [`DATA_WIDTH-1:0] alu_result_o,
    output logic [`DATA_WIDTH-1:0] pc_target_o,
    output logic                   take_branch_o
);

    logic [`DATA_WIDTH-1:0] src_a, src_b;
    logic [`DATA_WIDTH-1:0] target_base, target_sum;
    logic                   cond;

    // Operand muxes
    assign src_a = src_a_zero_i ? '0 : (src_a_pc_i ? pc_i : rs1_data_i);
    assign src_b = src_b_imm_i ? imm_i : rs2_data_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_result_o = src_a + src_b;
            ALU_SUB:    alu_result_o = src_a - src_b;
            ALU_AND:    alu_result_o = src_a & src_b;
            ALU_OR:     alu_result_o = src_a | src_b;
            ALU_XOR:    alu_result_o = src_a ^ src_b;
            ALU_SLT:    alu_result_o = {{(`DATA_WIDTH-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLL:    alu_result_o = src_a << src_b[4:0]; // Low five bits only
            ALU_SRL:    alu_result_o = src_a >> src_b[4:0];
            ALU_PASS_B: alu_result_o = src_b;
            default:    alu_result_o = src_a + src_b;
        endcase
    end

    // Branch compare on the raw register values
    always_comb begin
        case (funct3_i)
            3'b000:  cond = (rs1_data_i == rs2_data_i);                  // BEQ
            3'b001:  cond = (rs1_data_i != rs2_data_i);                  // BNE
            3'b100:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i)); // BLT
            3'b101:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i)); // BGE
            default: cond = 1'b0; // unsigned forms left out
        endcase
    end

    assign take_branch_o = jump_i | (branch_i & cond);

    // JALR jumps off rs1, everything else off the PC
    assign target_base = jalr_i ? rs1_data_i : pc_i;
    assign target_sum  = target_base + imm_i;
    assign pc_target_o = {target_sum[`DATA_WIDTH-1:1], target_sum[0] & ~jalr_i}; // Bit 0 cleared

endmodule

`default_nettype wire

//--- rtl/data_mem.sv
`default_nettype none
`include "rv_macros.svh"

module data_mem (
    input  logic                   clk,
    input  logic [`DMEM_AW-1:0]    addr_i,    // Word address
    input  logic [`DATA_WIDTH-1:0] wr_data_i,
    input  logic                   wr_en_i,
    output logic [`DATA_WIDTH-1:0] rd_data_o
);

    logic [`DATA_WIDTH-1:0] mem [`DMEM_DEPTH];

    // Whole-word stores only
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[addr_i] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[addr_i]; // Load data same cycle

endmodule

`default_nettype wire

//--- rtl/top.sv
`default_nettype none
`include "rv_macros.svh"

module top import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   imem_wr_en_i,
    input  logic [`IMEM_AW-1:0]    imem_wr_addr_i,
    input  logic [`DATA_WIDTH-1:0] imem_wr_data_i,
    output logic [`DATA_WIDTH-1:0] a0_o
);

    // Fetch
    logic [`DATA_WIDTH-1:0] pc, pc_plus4, pc_target;
    logic                   take_branch;
    rv_instr_u              instr;

    // Decode
    logic [4:0]             rs1_addr, rs2_addr, rd_addr;
    logic [`DATA_WIDTH-1:0] imm;
    alu_op_e                alu_op;
    logic                   src_a_pc, src_a_zero, src_b_imm;
    logic                   ctrl_reg_wr_en, ctrl_mem_wr_en;
    logic                   reg_wr_en, mem_wr_en; // After reset gating
    logic [1:0]             result_sel;
    logic                   branch, jump, jalr;

    logic [`DATA_WIDTH-1:0] rs1_data, rs2_data;
    logic [`DATA_WIDTH-1:0] alu_result, load_data, wb_data;

    fetch_unit u_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .take_branch_i  (take_branch),
        .pc_target_i    (pc_target),
        .imem_wr_en_i   (imem_wr_en_i),
        .imem_wr_addr_i (imem_wr_addr_i),
        .imem_wr_data_i (imem_wr_data_i),
        .pc_o           (pc),
        .pc_plus4_o     (pc_plus4),
        .instr_o        (instr)
    );

    control_unit u_ctrl (
        .instr_i      (instr),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rd_addr_o    (rd_addr),
        .imm_o        (imm),
        .alu_op_o     (alu_op),
        .src_a_pc_o   (src_a_pc),
        .src_a_zero_o (src_a_zero),
        .src_b_imm_o  (src_b_imm),
        .reg_wr_en_o  (ctrl_reg_wr_en),
        .mem_wr_en_o  (ctrl_mem_wr_en),
        .result_sel_o (result_sel),
        .branch_o     (branch),
        .jump_o       (jump),
        .jalr_o       (jalr)
    );

    // No state changes while held in reset, including during program load
    assign reg_wr_en = ctrl_reg_wr_en & ~reset_i;
    assign mem_wr_en = ctrl_mem_wr_en & ~reset_i;

    register_file u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (wb_data),
        .wr_en_i    (reg_wr_en),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .a0_o       (a0_o)
    );

    execute_unit u_exec (
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .imm_i         (imm),
        .alu_op_i      (alu_op),
        .src_a_pc_i    (src_a_pc),
        .src_a_zero_i  (src_a_zero),
        .src_b_imm_i   (src_b_imm),
        .branch_i      (branch),
        .jump_i        (jump),
        .jalr_i        (jalr),
        .funct3_i      (instr.b.funct3), // Only branches look at it
        .alu_result_o  (alu_result),
        .pc_target_o   (pc_target),
        .take_branch_o (take_branch)
    );

    data_mem u_dmem (
        .clk       (clk),
        .addr_i    (alu_result[`DMEM_AW+1:2]), // byte address to word index
        .wr_data_i (rs2_data),
        .wr_en_i   (mem_wr_en),
        .rd_data_o (load_data)
    );

    // Write-back select
    always_comb begin
        case (result_sel)
            2'd1:    wb_data = load_data;
            2'd2:    wb_data = pc_plus4; // Link address
            default: wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

//--- verification/top_asserts.sv
`default_nettype none
`include "rv_macros.svh"

module top_asserts (
    input logic                   clk,
    input logic                   reset_i,
    input logic [`DATA_WIDTH-1:0] pc_i,
    input logic [4:0]             rs1_addr_i,
    input logic [`DATA_WIDTH-1:0] rs1_data_i,
    input logic [4:0]             rs2_addr_i,
    input logic [`DATA_WIDTH-1:0] rs2_data_i,
    input logic                   mem_wr_en_i  // Gated store enable
);
    timeunit 1ns;
    timeprecision 100ps;

    // Fetch never leaves word alignment
    pc_aligned: assert property (@(posedge clk) disable iff (reset_i) pc_i[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc_i);

    pc_zero_after_reset: assert property (@(posedge clk) reset_i |=> pc_i == '0)
        else $error("PC not zero in the cycle after reset: %h", pc_i);

    // x0 reads as zero on both ports
    x0_rs1_zero: assert property (@(posedge clk) disable iff (reset_i)
        (rs1_addr_i == 5'd0) |-> (rs1_data_i == '0))
        else $error("x0 read on rs1 port returned %h", rs1_data_i);
    x0_rs2_zero: assert property (@(posedge clk) disable iff (reset_i)
        (rs2_addr_i == 5'd0) |-> (rs2_data_i == '0))
        else $error("x0 read on rs2 port returned %h", rs2_data_i);

    no_store_in_reset: assert property (@(posedge clk) reset_i |-> !mem_wr_en_i)
        else $error("Data memory write enabled during reset");

endmodule

bind top top_asserts u_asserts (
    .clk         (clk),
    .reset_i     (reset_i),
    .pc_i        (pc),
    .rs1_addr_i  (rs1_addr),
    .rs1_data_i  (rs1_data),
    .rs2_addr_i  (rs2_addr),
    .rs2_data_i  (rs2_data),
    .mem_wr_en_i (mem_wr_en)
);

`default_nettype wire

//--- verification/tb_top.sv
`default_nettype none
`include "rv_macros.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    // RV32I major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [31:0] NOP      = 32'h0000_0013; // addi x0, x0, 0
    // Up to six runs of 10 reset plus 40 program cycles, and some margin
    localparam int MAX_CYCLES = 6 * (10 + 40) + 100;

    logic                   clk;
    logic                   reset_i;
    logic                   imem_wr_en_i;
    logic [`IMEM_AW-1:0]    imem_wr_addr_i;
    logic [`DATA_WIDTH-1:0] imem_wr_data_i;
    logic [`DATA_WIDTH-1:0] a0_o;

    logic [31:0] prog [$];     // Program words
    int          chk_edge [$]; // Commit edge of each check
    logic [31:0] chk_val [$];
    logic [31:0] lfsr_state = 32'h9eb9;
    logic [31:0] a0_model;     // Branch test counter
    int          exec_edge;
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;

    top uut (
        .clk            (clk),
        .reset_i        (reset_i),
        .imem_wr_en_i   (imem_wr_en_i),
        .imem_wr_addr_i (imem_wr_addr_i),
        .imem_wr_data_i (imem_wr_data_i),
        .a0_o           (a0_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("ERROR: timeout, tests still running after %0d cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_next_bit()}; // One step per bit
        end
        return v;
    endfunction

    function automatic logic [31:0] sign_extend12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Instruction encoders
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE}; // SW only
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic start_program();
        prog.delete();
        chk_edge.delete();
        chk_val.delete();
    endtask

    task automatic expect_at(input int edge_no, input logic [31:0] value);
        chk_edge.push_back(edge_no);
        chk_val.push_back(value);
    endtask

    // LUI plus ADDI, upper part rounded for the signed low part
    task automatic push_li(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] sum;
        sum = value + 32'h800;
        prog.push_back(encode_u(sum[31:12], rd, OP_LUI));
        prog.push_back(encode_i(value[11:0], rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic check_a0(input logic [31:0] expected, input string what, input int edge_no);
        checks++;
        if (a0_o !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s, edge %0d: a0 = %08h, expected %08h",
                     $time, what, edge_no, a0_o, expected);
        end
    endtask

    // Load under reset, release, then check a0 at each listed commit edge
    task automatic run_program(input string name);
        int n_reset;
        int idx;
        int last;
        n_reset = (prog.size() + 4 > 10) ? prog.size() + 4 : 10; // At least 4 NOPs behind
        reset_i = 1'b1;
        for (int k = 0; k < n_reset; k++) begin
            imem_wr_en_i   = 1'b1;
            imem_wr_addr_i = `IMEM_AW'(k);
            imem_wr_data_i = (k < prog.size()) ? prog[k] : NOP;
            @(posedge clk);
            #1;
        end
        imem_wr_en_i = 1'b0;
        reset_i      = 1'b0;
        idx  = 0;
        last = chk_edge[chk_edge.size()-1];
        for (int e = 1; e <= last; e++) begin
            @(posedge clk); // Instruction e-1 commits here
            #1;
            while (idx < chk_edge.size() && chk_edge[idx] == e) begin
                check_a0(chk_val[idx], name, e);
                idx++;
            end
        end
    endtask

    task automatic push_rr(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] exp_v);
        prog.push_back(encode_r(f7, 5'd6, 5'd5, f3, 5'd10)); // a0 = x5 op x6
        expect_at(prog.size(), exp_v);
    endtask

    task automatic push_ri(input logic [2:0] f3, input logic [11:0] imm, input logic [31:0] exp_v);
        prog.push_back(encode_i(imm, 5'd5, f3, 5'd10, OP_IMM));
        expect_at(prog.size(), exp_v);
    endtask

    task automatic test_arithmetic();
        logic [31:0] a, b, t, simm;
        start_program();
        a = random_bits(32);
        b = random_bits(32);
        push_li(5'd5, a);
        push_li(5'd6, b);
        push_rr(7'h00, 3'b000, a + b);
        push_rr(7'h20, 3'b000, a - b);
        push_rr(7'h00, 3'b111, a & b);
        push_rr(7'h00, 3'b110, a | b);
        push_rr(7'h00, 3'b100, a ^ b);
        push_rr(7'h00, 3'b010, {31'b0, $signed(a) < $signed(b)});
        push_rr(7'h00, 3'b001, a << b[4:0]);
        push_rr(7'h00, 3'b101, a >> b[4:0]);
        // I-type forms, fresh immediate each
        t = random_bits(12);
        simm = sign_extend12(t[11:0]);
        push_ri(3'b000, t[11:0], a + simm);
        t = random_bits(12);
        simm = sign_extend12(t[11:0]);
        push_ri(3'b111, t[11:0], a & simm);
        t = random_bits(12);
        simm = sign_extend12(t[11:0]);
        push_ri(3'b110, t[11:0], a | simm);
        t = random_bits(12);
        simm = sign_extend12(t[11:0]);
        push_ri(3'b100, t[11:0], a ^ simm);
        t = random_bits(12);
        simm = sign_extend12(t[11:0]);
        push_ri(3'b010, t[11:0], {31'b0, $signed(a) < $signed(simm)});
        run_program("arithmetic");
    endtask

    task automatic test_memory();
        logic [31:0] v1, v2, r;
        logic [7:0]  addr1, diff;
        logic [11:0] off;
        start_program();
        v1 = random_bits(32);
        v2 = random_bits(32);
        r = random_bits(6);
        addr1 = {r[5:0], 2'b00};
        r = random_bits(5);
        diff = {1'b0, r[4:0], 2'b00} + 8'd4; // Always a different word
        off = {4'b0000, diff};
        push_li(5'd5, v1);
        push_li(5'd6, v2);
        prog.push_back(encode_i({4'b0000, addr1}, 5'd0, 3'b000, 5'd7, OP_IMM));
        prog.push_back(encode_s(12'd0, 5'd5, 5'd7));
        prog.push_back(encode_s(off, 5'd6, 5'd7));
        prog.push_back(encode_i(off, 5'd7, 3'b010, 5'd10, OP_LOAD)); // Reverse order
        expect_at(8, v2);
        prog.push_back(encode_i(12'd0, 5'd7, 3'b010, 5'd10, OP_LOAD));
        expect_at(9, v1);
        run_program("memory");
    endtask

    // Branch over an increment of a0
    task automatic push_branch_block(input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input logic [31:0] v1,
                                     input logic [31:0] v2);
        logic taken;
        case (f3)
            3'b000:  taken = (v1 == v2);
            3'b001:  taken = (v1 != v2);
            3'b100:  taken = ($signed(v1) < $signed(v2));
            default: taken = ($signed(v1) >= $signed(v2));
        endcase
        prog.push_back(encode_b(13'd8, rs2, rs1, f3));
        prog.push_back(encode_i(12'd1, 5'd10, 3'b000, 5'd10, OP_IMM));
        if (!taken) begin
            a0_model++;
        end
        expect_at(exec_edge + 2, a0_model); // Edge where the ADDI commits when not taken
        exec_edge += taken ? 1 : 2;
    endtask

    task automatic test_branches();
        logic [31:0] a, b, t;
        start_program();
        a = random_bits(32);
        t = random_bits(32);
        b = a ^ (t | 32'd1); // Never equal to a
        push_li(5'd5, a);
        push_li(5'd6, b);
        prog.push_back(encode_i(12'd0, 5'd5, 3'b000, 5'd7, OP_IMM)); // x7 = a
        exec_edge = 5;
        a0_model  = '0;
        push_branch_block(3'b000, 5'd5, 5'd7, a, a);
        push_branch_block(3'b000, 5'd5, 5'd6, a, b);
        push_branch_block(3'b001, 5'd5, 5'd6, a, b);
        push_branch_block(3'b001, 5'd5, 5'd7, a, a);
        push_branch_block(3'b100, 5'd5, 5'd6, a, b);
        push_branch_block(3'b100, 5'd6, 5'd5, b, a);
        push_branch_block(3'b101, 5'd5, 5'd6, a, b);
        push_branch_block(3'b101, 5'd6, 5'd5, b, a);
        run_program("branches");
    endtask

    task automatic test_jumps();
        start_program();
        prog.push_back(encode_j(21'd8, 5'd10));                          // 0: jal a0, +8
        prog.push_back(encode_i(12'd99, 5'd0, 3'b000, 5'd10, OP_IMM));   // 1: skipped
        prog.push_back(encode_i(12'd13, 5'd0, 3'b000, 5'd6, OP_IMM));    // 2: x6 = 13
        prog.push_back(encode_i(12'd8, 5'd6, 3'b000, 5'd10, OP_JALR));   // 3: to 21, lands on 20
        prog.push_back(encode_i(12'd77, 5'd0, 3'b000, 5'd10, OP_IMM));   // 4: skipped
        prog.push_back(encode_u(20'd0, 5'd10, OP_AUIPC));                // 5: a0 = PC
        expect_at(1, 32'd4);
        expect_at(2, 32'd4);
        expect_at(3, 32'd16);
        expect_at(4, 32'd20);
        run_program("jumps");
    endtask

    task automatic test_upper_x0_reset();
        logic [31:0] u1, u2;
        start_program();
        u1 = random_bits(20);
        u2 = random_bits(20);
        prog.push_back(encode_u(u1[19:0], 5'd10, OP_LUI));
        expect_at(1, {u1[19:0], 12'h000});
        prog.push_back(encode_u(u2[19:0], 5'd10, OP_AUIPC));          // PC is 4
        expect_at(2, 32'd4 + {u2[19:0], 12'h000});
        prog.push_back(encode_i(12'd5, 5'd10, 3'b000, 5'd0, OP_IMM));  // Write to x0
        expect_at(3, 32'd4 + {u2[19:0], 12'h000});
        prog.push_back(encode_i(12'd0, 5'd0, 3'b000, 5'd10, OP_IMM));  // a0 = x0
        expect_at(4, 32'd0);
        prog.push_back(encode_i(12'd3, 5'd10, 3'b000, 5'd10, OP_IMM));
        expect_at(5, 32'd3);
        prog.push_back(encode_i(12'd100, 5'd10, 3'b000, 5'd10, OP_IMM)); // Cut off by reset
        run_program("upper immediates and x0");
        reset_i = 1'b1;
        @(posedge clk);
        #1;
        check_a0(32'd0, "reset mid-program", 6);
        @(posedge clk);
        #1;
        reset_i = 1'b0;
        @(posedge clk); // First instruction again
        #1;
        check_a0({u1[19:0], 12'h000}, "restart at address 0", 1);
    endtask

    initial begin
        reset_i        = 1'b1;
        imem_wr_en_i   = 1'b0;
        imem_wr_addr_i = '0;
        imem_wr_data_i = '0;
        @(posedge clk);
        #1;
        test_arithmetic();
        test_memory();
        test_branches();
        test_jumps();
        test_upper_x0_reset();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/fetch_unit.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/data_mem.sv
rtl/top.sv
verification/top_asserts.sv
verification/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_top -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** TEST PASSED ***" "$LOG"; then
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi
